/* hw/input_pkg.sv */
`default_nettype none

package input_pkg;

	localparam int JOY_W = 16;
	localparam int KEY_CNT = 12;	// Keypad is 4 rows of 3

	// Bit positions in a host joystick word
	typedef enum logic [3:0] {
		JB_RIGHT  = 4'd0,
		JB_LEFT   = 4'd1,
		JB_DOWN   = 4'd2,
		JB_UP     = 4'd3,
		JB_FIRE1  = 4'd4,
		JB_FIRE2  = 4'd5,
		JB_PAUSE  = 4'd6,
		JB_SELECT = 4'd7,
		JB_START  = 4'd8,
		JB_AUX    = 4'd9	// Booster grip extra button
	} joy_bit_e;

	// Device codes in menu order, gaps are devices not built here
	typedef enum logic [3:0] {
		DEV_NONE      = 4'd0,
		DEV_JOYSTICK  = 4'd1,
		DEV_TRACKBALL = 4'd4,
		DEV_KEYPAD    = 4'd5,
		DEV_BOOSTER   = 4'd9
	} device_e;

	// Cartridge header controller byte
	function automatic device_e header_to_device(input logic [7:0] code);
		case (code)
			8'd1, 8'd5: return DEV_JOYSTICK;	// 7800 and 2600 sticks
			8'd4: return DEV_TRACKBALL;
			8'd7: return DEV_KEYPAD;
			default: return DEV_NONE;
		endcase
	endfunction

	typedef struct packed {
		logic [JOY_W-1:0] joy_a;
		logic [JOY_W-1:0] joy_b;
		device_e type_a;
		device_e type_b;
	} sel_t;

	// PS/2 mouse packet as delivered by the host
	typedef struct packed {
		logic toggle;
		logic [7:0] y;
		logic [7:0] x;
		logic [1:0] ovf;	// Overflow flags, not used
		logic sign_y;
		logic sign_x;
		logic [1:0] misc;	// Middle button and sync bit, not used
		logic [1:0] buttons;
	} mouse_t;

	typedef struct packed {
		logic toggle;
		logic pressed;
		logic [8:0] code;
	} key_event_t;

endpackage

`default_nettype wire

/* hw/riot_pkg.sv */
`default_nettype none

package riot_pkg;

	// Idle levels of the console input pins
	localparam logic [7:0] PA_IDLE = 8'hff;
	localparam logic [1:0] IL_IDLE = 2'b11;
	localparam logic [3:0] ID_IDLE = 4'b0000;
	localparam logic [7:0] PB_IDLE = 8'hff;	// Switches released

	// Keypad column lines of one port
	typedef struct packed {
		logic col_hash;	// 3, 6, 9, #
		logic col_mid;	// 2, 5, 8, 0
		logic col_star;	// 1, 4, 7, *
	} kp_cols_t;

	typedef struct packed {
		logic ytog;
		logic dir_y;
		logic xtog;
		logic dir_x;
		logic button;
	} track_t;

	// Pins owned by one controller port
	typedef struct packed {
		logic [3:0] nibble;	// RIOT port A half
		logic ilatch;
		logic [1:0] idump;
	} port_pins_t;

	localparam port_pins_t PORT_NONE = 7'b1111_1_00;

endpackage

`default_nettype wire

/* hw/controller_select.sv */
`timescale 1ns/1ps
`default_nettype none

module controller_select (
	input  logic clk_sys,
	input  logic reset,
	input  logic [input_pkg::JOY_W-1:0] joy_a,
	input  logic [input_pkg::JOY_W-1:0] joy_b,
	input  logic swap,
	input  logic tia_en,
	input  logic [3:0] sel_a,
	input  logic [3:0] sel_b,
	input  logic [7:0] header_a,
	input  logic [7:0] header_b,
	output input_pkg::sel_t sel
);

	// Menu entries without hardware here read as nothing plugged in
	function automatic input_pkg::device_e menu_to_device(input logic [3:0] code);
		case (code)
			4'd1: return input_pkg::DEV_JOYSTICK;
			4'd4: return input_pkg::DEV_TRACKBALL;
			4'd5: return input_pkg::DEV_KEYPAD;
			4'd9: return input_pkg::DEV_BOOSTER;
			default: return input_pkg::DEV_NONE;
		endcase
	endfunction

	function automatic input_pkg::device_e resolve(
		input logic [3:0] menu,
		input logic [7:0] header,
		input logic tia
	);
		input_pkg::device_e dev;
		if (menu != 4'd0)
			return menu_to_device(menu - 4'd1);	// Override beats header
		dev = input_pkg::header_to_device(header);
		// 2600 carts get sticks instead of a header trackball
		if (tia && dev == input_pkg::DEV_TRACKBALL)
			dev = input_pkg::DEV_JOYSTICK;
		return dev;
	endfunction

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sel <= '0;
		end else begin
			sel.joy_a <= swap ? joy_b : joy_a;
			sel.joy_b <= swap ? joy_a : joy_b;
			sel.type_a <= resolve(sel_a, header_a, tia_en);
			sel.type_b <= resolve(sel_b, header_b, tia_en);
		end
	end

	type_known: assert property (@(posedge clk_sys) disable iff (reset)
		sel.type_a inside {input_pkg::DEV_NONE, input_pkg::DEV_JOYSTICK,
			input_pkg::DEV_TRACKBALL, input_pkg::DEV_KEYPAD, input_pkg::DEV_BOOSTER} &&
		sel.type_b inside {input_pkg::DEV_NONE, input_pkg::DEV_JOYSTICK,
			input_pkg::DEV_TRACKBALL, input_pkg::DEV_KEYPAD, input_pkg::DEV_BOOSTER});

endmodule

`default_nettype wire

/* hw/keypad_matrix.sv */
`timescale 1ns/1ps
`default_nettype none

module keypad_matrix (
	input  logic clk_sys,
	input  logic reset,
	input  input_pkg::key_event_t key_ev,
	input  logic [7:0] pa_out,
	output riot_pkg::kp_cols_t cols_a,
	output riot_pkg::kp_cols_t cols_b
);

	// Slot is 3*row + col, col 0 being the star column
	logic [input_pkg::KEY_CNT-1:0] keys;
	logic last_tog;
	logic [3:0] key_idx;

	// Number row or the Q-W-E block, 15 for anything else
	function automatic logic [3:0] key_index(input logic [8:0] code);
		case (code)
			9'h016: return 4'd0;	// 1
			9'h01e: return 4'd1;	// 2
			9'h026: return 4'd2;	// 3
			9'h025, 9'h015: return 4'd3;	// 4 or Q
			9'h02e, 9'h01d: return 4'd4;
			9'h036, 9'h024: return 4'd5;
			9'h03d, 9'h01c: return 4'd6;	// 7 or A
			9'h03e, 9'h01b: return 4'd7;
			9'h046, 9'h023: return 4'd8;
			9'h055, 9'h01a: return 4'd9;	// *
			9'h045, 9'h022: return 4'd10;	// 0
			9'h04e, 9'h021: return 4'd11;	// #
			default: return 4'd15;
		endcase
	endfunction

	// A held key ties its column to its row line
	// Rows scanned upward so the highest pressed row sets the level
	function automatic riot_pkg::kp_cols_t scan(
		input logic [input_pkg::KEY_CNT-1:0] k,
		input logic [3:0] rows
	);
		logic [2:0] lv;
		lv = 3'b111;	// Pull-ups
		for (int r = 0; r < 4; r++) begin
			for (int c = 0; c < 3; c++) begin
				if (k[3*r + c])
					lv[c] = rows[r];
			end
		end
		return riot_pkg::kp_cols_t'(lv);
	endfunction

	assign key_idx = key_index(key_ev.code);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			keys <= '0;
			last_tog <= key_ev.toggle;	// Nothing pending out of reset
		end else if (key_ev.toggle != last_tog) begin
			last_tog <= key_ev.toggle;
			if (key_idx < 4'(input_pkg::KEY_CNT))
				keys[key_idx] <= key_ev.pressed;
		end
	end

	// Port A drives rows on 7:4, port B on 3:0
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cols_a <= '1;
			cols_b <= '1;
		end else begin
			cols_a <= scan(keys, pa_out[7:4]);
			cols_b <= scan(keys, pa_out[3:0]);
		end
	end

	keys_need_event: assert property (@(posedge clk_sys) disable iff (reset)
		$past(key_ev.toggle == last_tog) |-> $stable(keys));

endmodule

`default_nettype wire

/* hw/trackball_feed.sv */
`timescale 1ns/1ps
`default_nettype none

module trackball_feed (
	input  logic clk_sys,
	input  logic reset,
	input  logic pa_read,
	input  input_pkg::mouse_t mouse,
	output riot_pkg::track_t track
);

	logic last_tog;
	logic load;
	logic [7:0] cnt_x;
	logic [7:0] cnt_y;
	logic xtog, ytog;
	logic dir_x, dir_y;
	logic button;
	logic [3:0] nibble;

	assign load = mouse.toggle != last_tog;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			last_tog <= mouse.toggle;
			cnt_x <= '0;
			cnt_y <= '0;
			xtog <= 1'b0;
			ytog <= 1'b0;
			dir_x <= 1'b0;
			dir_y <= 1'b0;
			button <= 1'b0;
			nibble <= '0;
		end else begin
			last_tog <= mouse.toggle;
			// One step of movement per port A read
			if (pa_read) begin
				nibble <= {ytog, dir_y, xtog, dir_x};	// Toggles before this read
				if (cnt_y != 8'd0) begin
					ytog <= ~ytog;
					cnt_y <= cnt_y - 8'd1;
				end
				if (cnt_x != 8'd0) begin
					xtog <= ~xtog;
					cnt_x <= cnt_x - 8'd1;
				end
			end
			// New packet overrides the counters
			if (load) begin
				cnt_x <= mouse.sign_x ? ~mouse.x : mouse.x;
				cnt_y <= mouse.sign_y ? ~mouse.y : mouse.y;
				dir_x <= ~mouse.sign_x;	// X axis is mirrored on this trackball
				dir_y <= mouse.sign_y;
				button <= |mouse.buttons;	// Either button fires
			end
		end
	end

	assign track = riot_pkg::track_t'({nibble, button});

	no_wrap: assert property (@(posedge clk_sys) disable iff (reset)
		!$past(load) |-> (cnt_x <= $past(cnt_x)) && (cnt_y <= $past(cnt_y)));

endmodule

`default_nettype wire

/* hw/port_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module port_mux (
	input  logic clk_sys,
	input  logic reset,
	input  logic tia_en,
	input  input_pkg::sel_t sel,
	input  riot_pkg::kp_cols_t cols_a,
	input  riot_pkg::kp_cols_t cols_b,
	input  riot_pkg::track_t track,
	input  logic [7:0] pa_out,
	input  logic [7:0] pb_out,
	input  logic diff_left,
	input  logic diff_right,
	input  logic bw,
	output logic [7:0] pa_in,
	output logic [1:0] ilatch,
	output logic [3:0] idump,
	output logic [7:0] pb_in
);

	input_pkg::device_e dev_b;
	riot_pkg::port_pins_t pins_a;
	riot_pkg::port_pins_t pins_b;
	logic pause, select, start;
	logic [7:0] pb_next;

	function automatic riot_pkg::port_pins_t map_port(
		input input_pkg::device_e dev,
		input logic [input_pkg::JOY_W-1:0] joy,
		input riot_pkg::kp_cols_t cols,
		input riot_pkg::track_t trk,
		input logic [3:0] echo,
		input logic tia,
		input logic two_btn
	);
		riot_pkg::port_pins_t p;
		logic f1, f2;
		f1 = joy[input_pkg::JB_FIRE1];
		f2 = joy[input_pkg::JB_FIRE2];
		// Stick wiring, active low
		p.nibble = ~{joy[input_pkg::JB_RIGHT], joy[input_pkg::JB_LEFT],
			joy[input_pkg::JB_DOWN], joy[input_pkg::JB_UP]};
		p.ilatch = tia ? ~f1 : ~(f1 | f2);	// One-button fire sees either
		p.idump = tia ? {~f2, 1'b0} : {f1, f2};
		case (dev)
			input_pkg::DEV_NONE: p = riot_pkg::PORT_NONE;
			input_pkg::DEV_TRACKBALL: begin
				p.nibble = {trk.ytog, trk.dir_y, trk.xtog, trk.dir_x};
				p.ilatch = ~trk.button;
				p.idump = 2'b00;
			end
			input_pkg::DEV_KEYPAD: begin
				p.nibble = echo;	// Row drive reads back
				p.ilatch = cols.col_hash;
				p.idump = {cols.col_mid, cols.col_star};
			end
			input_pkg::DEV_BOOSTER: p.idump = {f2, joy[input_pkg::JB_AUX]};
			default: ;
		endcase
		// Two-button mode pulls pin 6 up hard
		if (two_btn)
			p.ilatch = 1'b1;
		return p;
	endfunction

	// Only one trackball feed, so a second one falls back to a stick
	assign dev_b = (sel.type_b == input_pkg::DEV_TRACKBALL &&
		sel.type_a == input_pkg::DEV_TRACKBALL) ? input_pkg::DEV_JOYSTICK : sel.type_b;

	assign pins_a = map_port(sel.type_a, sel.joy_a, cols_a, track, pa_out[7:4],
		tia_en, ~tia_en & ~pb_out[2]);
	assign pins_b = map_port(dev_b, sel.joy_b, cols_b, track, pa_out[3:0],
		tia_en, ~tia_en & ~pb_out[4]);

	assign pause = sel.joy_a[input_pkg::JB_PAUSE] | sel.joy_b[input_pkg::JB_PAUSE];
	assign select = sel.joy_a[input_pkg::JB_SELECT] | sel.joy_b[input_pkg::JB_SELECT];
	assign start = sel.joy_a[input_pkg::JB_START] | sel.joy_b[input_pkg::JB_START];

	always_comb begin
		pb_next[7] = ~diff_right;
		pb_next[6] = ~diff_left;
		pb_next[5] = pb_out[5];	// Not connected
		pb_next[4] = pb_out[4];	// Port B button mode
		pb_next[3] = tia_en ? ~bw : ~pause;
		pb_next[2] = pb_out[2];	// Port A button mode
		pb_next[1] = ~select;
		pb_next[0] = ~start;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pa_in <= riot_pkg::PA_IDLE;
			ilatch <= riot_pkg::IL_IDLE;
			idump <= riot_pkg::ID_IDLE;
			pb_in <= riot_pkg::PB_IDLE;
		end else begin
			pa_in <= {pins_a.nibble, pins_b.nibble};
			ilatch <= {pins_b.ilatch, pins_a.ilatch};
			idump <= {pins_b.idump, pins_a.idump};
			pb_in <= pb_next;
		end
	end

	none_a_quiet: assert property (@(posedge clk_sys) disable iff (reset)
		$past(sel.type_a) == input_pkg::DEV_NONE |-> idump[1:0] == 2'b00);
	none_b_quiet: assert property (@(posedge clk_sys) disable iff (reset)
		$past(sel.type_b) == input_pkg::DEV_NONE |-> idump[3:2] == 2'b00);

endmodule

`default_nettype wire

/* hw/riot_input_top.sv */
`timescale 1ns/1ps
`default_nettype none

module riot_input_top (
	input  logic clk_sys,
	input  logic reset,
	input  logic [input_pkg::JOY_W-1:0] joy_a,
	input  logic [input_pkg::JOY_W-1:0] joy_b,
	input  logic swap,
	input  logic [3:0] sel_a,
	input  logic [3:0] sel_b,
	input  logic [7:0] header_a,
	input  logic [7:0] header_b,
	input  logic tia_en,
	input  logic diff_left,
	input  logic diff_right,
	input  logic bw,
	input  input_pkg::key_event_t key_ev,
	input  input_pkg::mouse_t mouse,
	input  logic pa_read,
	input  logic [7:0] pa_out,
	input  logic [7:0] pb_out,
	output logic [7:0] pa_in,
	output logic [1:0] ilatch,
	output logic [3:0] idump,
	output logic [7:0] pb_in
);

	input_pkg::sel_t sel_q;
	riot_pkg::kp_cols_t cols_a;
	riot_pkg::kp_cols_t cols_b;
	riot_pkg::track_t track;

	controller_select u_select (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.joy_a    (joy_a),
		.joy_b    (joy_b),
		.swap     (swap),
		.tia_en   (tia_en),
		.sel_a    (sel_a),
		.sel_b    (sel_b),
		.header_a (header_a),
		.header_b (header_b),
		.sel      (sel_q)
	);

	keypad_matrix u_keypad (
		.clk_sys (clk_sys),
		.reset   (reset),
		.key_ev  (key_ev),
		.pa_out  (pa_out),
		.cols_a  (cols_a),
		.cols_b  (cols_b)
	);

	trackball_feed u_trackball (
		.clk_sys (clk_sys),
		.reset   (reset),
		.pa_read (pa_read),
		.mouse   (mouse),
		.track   (track)
	);

	port_mux u_mux (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.tia_en     (tia_en),
		.sel        (sel_q),
		.cols_a     (cols_a),
		.cols_b     (cols_b),
		.track      (track),
		.pa_out     (pa_out),
		.pb_out     (pb_out),
		.diff_left  (diff_left),
		.diff_right (diff_right),
		.bw         (bw),
		.pa_in      (pa_in),
		.ilatch     (ilatch),
		.idump      (idump),
		.pb_in      (pb_in)
	);

endmodule

`default_nettype wire

/* tests/riot_input_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module riot_input_tb;

	localparam int RAND_STEPS = 40;
	localparam int KEY_CODES = 21;	// 1, 2, 3 have one code, the other keys two
	localparam int TIMEOUT_CYCLES = 4000;	// Whole run is near 450 cycles

	logic clk_sys = 1'b0;
	logic reset = 1'b1;
	logic [15:0] joy_a, joy_b;
	logic swap, tia_en, diff_left, diff_right, bw, pa_read;
	logic [3:0] sel_a, sel_b;
	logic [7:0] header_a, header_b, pa_out, pb_out;
	input_pkg::key_event_t key_ev;
	input_pkg::mouse_t mouse;
	logic [7:0] pa_in, pb_in;
	logic [1:0] ilatch;
	logic [3:0] idump;

	logic [31:0] lfsr_state = 32'hda61;
	logic [11:0] key_down;	// Slot 3*row + col, col 0 star, 1 mid, 2 hash
	logic [7:0] cnt_x_m, cnt_y_m;
	logic xtog_m, ytog_m, dir_x_m, dir_y_m;
	logic [3:0] trk_nib;
	logic trk_btn;
	logic [7:0] exp_pa, exp_pb;
	logic [1:0] exp_il;
	logic [3:0] exp_id;
	int req_count = 0;
	int done_count = 0;
	int check_count = 0;
	int error_count = 0;
	int cycle_count = 0;
	int test_checks, test_errors;

	logic [8:0] key_codes [KEY_CODES] = '{9'h016, 9'h01e, 9'h026, 9'h025, 9'h02e, 9'h036,
		9'h03d, 9'h03e, 9'h046, 9'h055, 9'h045, 9'h04e, 9'h015, 9'h01d, 9'h024, 9'h01c,
		9'h01b, 9'h023, 9'h01a, 9'h022, 9'h021};
	int key_slots [KEY_CODES] = '{0, 1, 2, 3, 4, 5, 6, 7, 8, 9, 10, 11,
		3, 4, 5, 6, 7, 8, 9, 10, 11};
	// Sticks, boosters and dropped codes only
	logic [3:0] sel_pick [8] = '{4'd0, 4'd0, 4'd1, 4'd2, 4'd3, 4'd10, 4'd4, 4'd8};
	logic [7:0] header_pick [8] = '{8'd0, 8'd1, 8'd5, 8'd2, 8'd3, 8'd6, 8'd9, 8'd1};

	riot_input_top dut (.*);

	always #2 clk_sys = ~clk_sys;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};	// Taps 32, 22, 2, 1
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// Menu override first, then the cartridge header
	function automatic int resolve_device(input logic [3:0] menu, input logic [7:0] header);
		int code;
		if (menu != 4'd0) begin
			code = int'(menu) - 1;
			return (code inside {1, 4, 5, 9}) ? code : 0;
		end
		case (header)
			8'd1, 8'd5: code = 1;
			8'd4: code = tia_en ? 1 : 4;	// 2600 carts keep sticks
			8'd7: code = 5;
			default: code = 0;
		endcase
		return code;
	endfunction

	// Columns as {hash, mid, star}, higher rows win
	function automatic logic [2:0] key_cols(input logic [3:0] rows);
		logic [2:0] lv;
		lv = 3'b111;
		for (int r = 0; r < 4; r++)
			for (int c = 0; c < 3; c++)
				if (key_down[3*r + c])
					lv[c] = rows[r];
		return lv;
	endfunction

	function automatic logic [6:0] port_pins(input int dev, input logic [15:0] j,
		input logic [2:0] cols, input logic [3:0] echo, input logic pull);
		logic [3:0] nib;
		logic il;
		logic [1:0] id;
		nib = 4'hf;
		il = 1'b1;
		id = 2'b00;
		if (dev == 1 || dev == 9) begin
			nib = ~{j[0], j[1], j[2], j[3]};	// R, L, D, U
			il = tia_en ? ~j[4] : ~(j[4] | j[5]);
			id = tia_en ? {~j[5], 1'b0} : {j[4], j[5]};
			if (dev == 9)
				id = {j[5], j[9]};	// Booster grip buttons
		end else if (dev == 4) begin
			nib = trk_nib;
			il = ~trk_btn;
		end else if (dev == 5) begin
			nib = echo;
			il = cols[2];
			id = cols[1:0];
		end
		if (pull)
			il = 1'b1;
		return {nib, il, id};
	endfunction

	function automatic logic [21:0] reference_outputs();
		logic [15:0] ja, jb;
		int dev_a, dev_b;
		logic [6:0] pins_a, pins_b;
		logic [7:0] pb;
		logic pause, sel_btn, start;
		ja = swap ? joy_b : joy_a;
		jb = swap ? joy_a : joy_b;
		dev_a = resolve_device(sel_a, header_a);
		dev_b = resolve_device(sel_b, header_b);
		if (dev_a == 4 && dev_b == 4)
			dev_b = 1;	// Single trackball feed
		pins_a = port_pins(dev_a, ja, key_cols(pa_out[7:4]), pa_out[7:4],
			!tia_en && !pb_out[2]);
		pins_b = port_pins(dev_b, jb, key_cols(pa_out[3:0]), pa_out[3:0],
			!tia_en && !pb_out[4]);
		pause = ja[6] | jb[6];
		sel_btn = ja[7] | jb[7];
		start = ja[8] | jb[8];
		pb = {~diff_right, ~diff_left, pb_out[5:4], tia_en ? ~bw : ~pause, pb_out[2],
			~sel_btn, ~start};
		return {pins_a[6:3], pins_b[6:3], pins_b[2], pins_a[2], pins_b[1:0], pins_a[1:0], pb};
	endfunction

	task automatic load_mouse_model();
		cnt_x_m = mouse.sign_x ? ~mouse.x : mouse.x;
		cnt_y_m = mouse.sign_y ? ~mouse.y : mouse.y;
		dir_x_m = ~mouse.sign_x;
		dir_y_m = mouse.sign_y;
		trk_btn = |mouse.buttons;
	endtask

	task automatic read_mouse_model();
		trk_nib = {ytog_m, dir_y_m, xtog_m, dir_x_m};	// Shown before the step
		if (cnt_y_m != 8'd0) begin
			ytog_m = ~ytog_m;
			cnt_y_m--;
		end
		if (cnt_x_m != 8'd0) begin
			xtog_m = ~xtog_m;
			cnt_x_m--;
		end
	endtask

	task automatic compare_value(input string field, input logic [7:0] got,
		input logic [7:0] want);
		check_count++;
		if (got !== want) begin
			error_count++;
			$display("Mismatch at time %0t: %s is %h, expected %h", $time, field, got, want);
		end
	endtask

	task automatic drive_step();
		@(posedge clk_sys);
		#1;
	endtask

	// Hand the expected values to the comparing process and wait for it
	task automatic request_check();
		req_count++;
		wait (done_count == req_count);
	endtask

	task automatic expect_after(input int cycles);
		repeat (cycles) @(posedge clk_sys);
		#1;
		{exp_pa, exp_il, exp_id, exp_pb} = reference_outputs();
		request_check();
	endtask

	task automatic start_test();
		test_checks = check_count;
		test_errors = error_count;
	endtask

	task automatic end_test(input string name);
		$display("%s: %0d checks, %0d errors", name, check_count - test_checks,
			error_count - test_errors);
	endtask

	task automatic apply_types(input logic [3:0] sa, input logic [7:0] ha,
		input logic [3:0] sb, input logic [7:0] hb, input logic tia);
		drive_step();
		sel_a = sa;
		header_a = ha;
		sel_b = sb;
		header_b = hb;
		tia_en = tia;
		joy_a = 16'(rand_bits(16));
		joy_b = 16'(rand_bits(16));
		pa_out = 8'(rand_bits(8));
		pb_out = 8'(rand_bits(8));
		expect_after(2);
	endtask

	always @(negedge clk_sys) begin
		if (done_count != req_count) begin
			compare_value("pa_in", pa_in, exp_pa);
			compare_value("ilatch", {6'd0, ilatch}, {6'd0, exp_il});
			compare_value("idump", {4'd0, idump}, {4'd0, exp_id});
			compare_value("pb_in", pb_in, exp_pb);
			done_count++;
		end
	end

	always @(posedge clk_sys) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAIL");
			$finish;
		end
	end

	initial begin
		joy_a = '0;
		joy_b = '0;
		{swap, tia_en, diff_left, diff_right, bw, pa_read} = '0;
		{sel_a, sel_b, header_a, header_b, pa_out, pb_out} = '0;
		key_ev = '0;
		mouse = '0;
		key_down = '0;
		{cnt_x_m, cnt_y_m, xtog_m, ytog_m, dir_x_m, dir_y_m, trk_nib, trk_btn} = '0;

		// Idle pins while reset is still held
		repeat (7) @(posedge clk_sys);
		#1;
		start_test();
		{exp_pa, exp_il, exp_id, exp_pb} = {8'hff, 2'b11, 4'b0000, 8'hff};
		request_check();
		end_test("Reset state");
		drive_step();
		reset = 1'b0;

		start_test();
		for (int n = 0; n < RAND_STEPS; n++) begin
			drive_step();
			joy_a = 16'(rand_bits(16));
			joy_b = 16'(rand_bits(16));
			{swap, tia_en, diff_left, diff_right, bw} = 5'(rand_bits(5));
			sel_a = sel_pick[3'(rand_bits(3))];
			sel_b = sel_pick[3'(rand_bits(3))];
			header_a = header_pick[3'(rand_bits(3))];
			header_b = header_pick[3'(rand_bits(3))];
			pa_out = 8'(rand_bits(8));
			pb_out = 8'(rand_bits(8));
			expect_after(2);
		end
		end_test("Random joystick states");

		start_test();
		drive_step();
		sel_a = 4'd6;	// Keypad on both ports
		sel_b = 4'd6;
		tia_en = 1'b0;
		for (int i = 0; i < KEY_CODES; i++) begin
			for (int p = 0; p < 2; p++) begin
				drive_step();
				pa_out = 8'(rand_bits(8));
				pb_out = 8'(rand_bits(8));
				key_ev = input_pkg::key_event_t'({~key_ev.toggle, p == 0, key_codes[i]});
				key_down[key_slots[i]] = (p == 0);
				expect_after(3);
			end
		end
		end_test("Keypad");

		start_test();
		drive_step();
		sel_a = 4'd5;	// Trackball on A, nothing on B
		sel_b = 4'd1;
		for (int k = 1; k <= 6; k++) begin
			drive_step();
			mouse = input_pkg::mouse_t'({~mouse.toggle, 24'(rand_bits(24))});
			pb_out = 8'(rand_bits(8));
			load_mouse_model();
			repeat (k) begin
				drive_step();
				pa_read = 1'b1;
				read_mouse_model();
			end
			drive_step();
			pa_read = 1'b0;
			expect_after(1);
		end
		end_test("Trackball");

		start_test();
		apply_types(4'd2, 8'd7, 4'd10, 8'd1, 1'b0);	// Overrides beat headers
		apply_types(4'd3, 8'd1, 4'd8, 8'd5, 1'b0);	// Dropped codes
		apply_types(4'd0, 8'd4, 4'd0, 8'd7, 1'b1);
		apply_types(4'd5, 8'd0, 4'd5, 8'd0, 1'b0);	// Two trackballs
		apply_types(4'd0, 8'd4, 4'd0, 8'd5, 1'b0);
		apply_types(4'd1, 8'd5, 4'd0, 8'd9, 1'b1);
		end_test("Type resolution");

		$display("All tests: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
hw/input_pkg.sv
hw/riot_pkg.sv
hw/controller_select.sv
hw/keypad_matrix.sv
hw/trackball_feed.sv
hw/port_mux.sv
hw/riot_input_top.sv
tests/riot_input_tb.sv

/* Makefile */
# Verilator flow for the controller front end

VERILATOR ?= verilator
TOP ?= riot_input_tb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --assert --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
